// File: Makefile
# Verilator build and run for the feature loader testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -sv
TOP       := tb_feature_loader
FILELIST  := build.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulation prints the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
design/feat_pkg.sv
design/feat_burst_ctrl.sv
design/feat_word_fifo.sv
design/rgb565_unpack.sv
design/feature_loader_top.sv
verif/ddr_burst_model.sv
verif/tb_feature_loader.sv

// File: design/feat_burst_ctrl.sv
// Stage 1 of the feature loader. Requests fixed-length DDR read bursts at
// consecutive addresses, and only when a whole burst fits in the word FIFO.
// The water level counts reserved words and drops as the FIFO retires them.
`timescale 1ns/100ps

module feat_burst_ctrl #(
    parameter int unsigned                     BURST_LEN     = 8,
    parameter int unsigned                     FIFO_DEPTH    = 32,
    parameter logic [feat_pkg::ADDR_WIDTH-1:0] IMG_BASE_ADDR = 32'h0001_0000
) (
    input  logic                  s_clk,
    input  logic                  s_rst,
    input  feat_pkg::ddr_rd_rsp_t i_ddr_rsp,
    input  logic                  i_word_pop,
    input  logic                  i_reload,
    output feat_pkg::ddr_rd_req_t o_ddr_req,
    output logic                  o_drop
);

    localparam int unsigned LVL_W = $clog2(FIFO_DEPTH + 1);
    localparam int unsigned LEN_W = feat_pkg::LEN_WIDTH;
    localparam logic [LVL_W-1:0] LVL_MAX = LVL_W'(FIFO_DEPTH - BURST_LEN);
    localparam logic [LVL_W-1:0] LVL_INC = LVL_W'(BURST_LEN);
    localparam logic [feat_pkg::ADDR_WIDTH-1:0] ADDR_STEP =
        BURST_LEN * (feat_pkg::DATA_WIDTH / 8);

    feat_pkg::burst_state_e          state;
    logic [feat_pkg::ADDR_WIDTH-1:0] addr;
    logic [LVL_W-1:0]                level;
    logic                            req;
    logic                            issue;

    // room for one more burst
    assign issue = (state == feat_pkg::ST_IDLE) && (level <= LVL_MAX) && !i_reload;

    assign o_ddr_req = '{req: req, addr: addr, len: LEN_W'(BURST_LEN)};
    assign o_drop    = (state == feat_pkg::ST_DRAIN);

    // level is reserved at request time, so gaps between beats do not matter
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            level <= '0;
        end else if (i_reload) begin
            level <= '0;
        end else begin
            level <= level + (issue ? LVL_INC : '0) - LVL_W'(i_word_pop);
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state <= feat_pkg::ST_IDLE;
            req   <= 1'b0;
            addr  <= IMG_BASE_ADDR;
        end else begin
            case (state)
                feat_pkg::ST_IDLE: begin
                    if (i_reload) begin
                        addr <= IMG_BASE_ADDR;
                    end else if (issue) begin
                        req   <= 1'b1;
                        state <= feat_pkg::ST_REQUEST;
                    end
                end
                feat_pkg::ST_REQUEST: begin
                    if (i_ddr_rsp.finish) begin
                        req   <= 1'b0;
                        state <= feat_pkg::ST_IDLE;
                        addr  <= i_reload ? IMG_BASE_ADDR : addr + ADDR_STEP;
                    end else if (i_reload) begin
                        state <= feat_pkg::ST_DRAIN; // addr held until the burst closes
                    end
                end
                feat_pkg::ST_DRAIN: begin
                    if (i_ddr_rsp.finish) begin
                        req   <= 1'b0;
                        state <= feat_pkg::ST_IDLE;
                        addr  <= IMG_BASE_ADDR;
                    end
                end
                default: state <= feat_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

// File: design/feat_pkg.sv
// Shared widths, FSM states and bus structs for the first-layer feature loader.
// Modules reach these through feat_pkg:: scoped names.
package feat_pkg;

    localparam int unsigned DATA_WIDTH = 64; // one DDR beat
    localparam int unsigned ADDR_WIDTH = 32; // byte address
    localparam int unsigned LEN_WIDTH  = 8;
    localparam int unsigned QUAN_BITS  = 8;  // per channel
    localparam int unsigned PIX_BITS   = 16; // rgb565

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST, // burst open, waiting for finish
        ST_DRAIN    // reload hit an open burst
    } burst_state_e;

    // toward the DDR read port
    typedef struct packed {
        logic                  req;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
    } ddr_rd_req_t;

    // from the DDR read port, finish comes with the last valid beat
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  valid;
        logic                  finish;
    } ddr_rd_rsp_t;

    typedef struct packed {
        logic [QUAN_BITS-1:0] ch0; // red
        logic [QUAN_BITS-1:0] ch1; // green
        logic [QUAN_BITS-1:0] ch2; // blue
    } feature_px_t;

endpackage

// File: design/feat_word_fifo.sv
// Stage 2 of the feature loader. Buffers 64-bit DDR beats and hands out one
// 16-bit RGB565 pixel per pop, low halfword first. Writes take priority over
// pops; reload flushes everything. o_word_pop pulses when a word is retired.
`timescale 1ns/100ps

module feat_word_fifo #(
    parameter int unsigned FIFO_DEPTH = 32
) (
    input  logic                          s_clk,
    input  logic                          s_rst,
    input  feat_pkg::ddr_rd_rsp_t         i_ddr_rsp,
    input  logic                          i_drop,
    input  logic                          i_reload,
    input  logic                          i_data_ready,
    output logic [feat_pkg::PIX_BITS-1:0] o_px,
    output logic                          o_px_valid,
    output logic                          o_word_pop
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    logic [feat_pkg::DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [feat_pkg::DATA_WIDTH-1:0] head_word;
    logic [PTR_W:0]                  wr_ptr; // extra bit tells full from empty
    logic [PTR_W:0]                  rd_ptr;
    logic [1:0]                      px_idx; // pixel within head word
    logic                            empty;
    logic                            wr_en;
    logic                            pop;
    logic                            last_px;

    assign empty     = (wr_ptr == rd_ptr);
    assign wr_en     = i_ddr_rsp.valid && !i_drop && !i_reload;
    assign pop       = !empty && i_data_ready && !wr_en && !i_reload;
    assign last_px   = (px_idx == 2'd3);
    assign head_word = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge s_clk) begin
        if (wr_en) begin
            mem[wr_ptr[PTR_W-1:0]] <= i_ddr_rsp.data;
        end
        if (pop) begin
            o_px <= head_word[px_idx * feat_pkg::PIX_BITS +: feat_pkg::PIX_BITS];
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            px_idx     <= 2'd0;
            o_px_valid <= 1'b0;
            o_word_pop <= 1'b0;
        end else begin
            o_px_valid <= pop;
            o_word_pop <= pop && last_px;

            if (i_reload) begin
                // flush, in-flight pixels still come out
                wr_ptr <= '0;
                rd_ptr <= '0;
                px_idx <= 2'd0;
            end else begin
                if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    px_idx <= px_idx + 2'd1; // wraps to 0 after the 4th
                    if (last_px) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: design/feature_loader_top.sv
// Input-feature loader for the first conv layer. Reads an RGB565 image from
// DDR in bursts and streams quantized 3-channel pixels to the consumer.
// i_reload restarts the image at IMG_BASE_ADDR.
`timescale 1ns/100ps

module feature_loader_top #(
    parameter int unsigned                     BURST_LEN     = 8,
    parameter int unsigned                     FIFO_DEPTH    = 32,
    parameter logic [feat_pkg::ADDR_WIDTH-1:0] IMG_BASE_ADDR = 32'h0001_0000
) (
    input  logic                  s_clk,
    input  logic                  s_rst,
    input  feat_pkg::ddr_rd_rsp_t i_ddr_rsp,
    output feat_pkg::ddr_rd_req_t o_ddr_req,
    input  logic                  i_data_ready,
    input  logic                  i_reload,
    output feat_pkg::feature_px_t o_pixel,
    output logic                  o_pixel_valid
);

    logic                          word_pop;
    logic                          drop;
    logic [feat_pkg::PIX_BITS-1:0] px;
    logic                          px_valid;

    feat_burst_ctrl #(
        .BURST_LEN     (BURST_LEN),
        .FIFO_DEPTH    (FIFO_DEPTH),
        .IMG_BASE_ADDR (IMG_BASE_ADDR)
    ) feat_burst_ctrl_inst (
        .s_clk      (s_clk),
        .s_rst      (s_rst),
        .i_ddr_rsp  (i_ddr_rsp),
        .i_word_pop (word_pop),
        .i_reload   (i_reload),
        .o_ddr_req  (o_ddr_req),
        .o_drop     (drop)
    );

    // beats go straight from DDR into the FIFO
    feat_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) feat_word_fifo_inst (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_ddr_rsp    (i_ddr_rsp),
        .i_drop       (drop),
        .i_reload     (i_reload),
        .i_data_ready (i_data_ready),
        .o_px         (px),
        .o_px_valid   (px_valid),
        .o_word_pop   (word_pop)
    );

    rgb565_unpack rgb565_unpack_inst (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_px          (px),
        .i_px_valid    (px_valid),
        .o_pixel       (o_pixel),
        .o_pixel_valid (o_pixel_valid)
    );

endmodule

// File: design/rgb565_unpack.sv
// Stage 3 of the feature loader. Registers one RGB565 pixel and spreads it
// into three 8-bit channels, each field left aligned with zero fill.
`timescale 1ns/100ps

module rgb565_unpack (
    input  logic                          s_clk,
    input  logic                          s_rst,
    input  logic [feat_pkg::PIX_BITS-1:0] i_px,
    input  logic                          i_px_valid,
    output feat_pkg::feature_px_t         o_pixel,
    output logic                          o_pixel_valid
);

    feat_pkg::feature_px_t px_q;

    always_comb begin
        px_q.ch0 = {i_px[15:11], 3'b000}; // red
        px_q.ch1 = {i_px[10:5], 2'b00};   // green
        px_q.ch2 = {i_px[4:0], 3'b000};   // blue
    end

    always_ff @(posedge s_clk) begin
        if (i_px_valid) begin
            o_pixel <= px_q;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_pixel_valid <= 1'b0;
        end else begin
            o_pixel_valid <= i_px_valid;
        end
    end

endmodule

// File: verif/ddr_burst_model.sv
// Behavioral DDR read slave for the feature loader testbench.
// Answers each burst request with address-hashed beats; i_gap inserts idle
// cycles between beats. Outputs change on the falling clock edge.
`timescale 1ns/100ps

module ddr_burst_model (
    input  logic                  s_clk,
    input  logic                  s_rst,
    input  feat_pkg::ddr_rd_req_t i_req,
    input  logic                  i_gap,
    output feat_pkg::ddr_rd_rsp_t o_rsp
);

    logic [feat_pkg::ADDR_WIDTH-1:0] req_q[$]; // every accepted request address
    logic [feat_pkg::ADDR_WIDTH-1:0] cur_addr;
    logic [feat_pkg::LEN_WIDTH-1:0]  burst_len;
    logic [feat_pkg::LEN_WIDTH-1:0]  beat;
    logic                            busy;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // fixed data per byte address
    function automatic logic [63:0] addr_hash(input logic [31:0] addr);
        return {xorshift32(addr), xorshift32(~addr)};
    endfunction

    always @(negedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_rsp     <= '0;
            busy      <= 1'b0;
            beat      <= '0;
            burst_len <= '0;
            req_q.delete();
        end else if (!busy) begin
            o_rsp <= '0;
            if (i_req.req) begin
                req_q.push_back(i_req.addr);
                burst_len <= i_req.len;
                beat      <= '0;
                busy      <= 1'b1;
            end
        end else if (i_gap) begin
            o_rsp <= '0; // idle cycle inside the burst
        end else begin
            cur_addr = req_q[req_q.size() - 1];
            o_rsp.data   <= addr_hash(cur_addr + 32'(beat) * 32'd8);
            o_rsp.valid  <= 1'b1;
            o_rsp.finish <= (beat == burst_len - 1'b1);
            beat         <= beat + 1'b1;
            if (beat == burst_len - 1'b1) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: verif/tb_feature_loader.sv
// Testbench for feature_loader_top. Random ready, beat gaps and reloads from
// an xorshift stream; pixels and burst requests are checked against a model
// of the image in DDR. Run through the Makefile with Verilator.
`timescale 1ns/100ps

module tb_feature_loader;

    localparam int unsigned BURST_LEN  = 8;
    localparam int unsigned FIFO_DEPTH = 32;
    localparam logic [feat_pkg::ADDR_WIDTH-1:0] IMG_BASE_ADDR = 32'h0001_0000;
    localparam logic [feat_pkg::ADDR_WIDTH-1:0] ADDR_STEP     = BURST_LEN * 8;
    localparam logic [feat_pkg::LEN_WIDTH-1:0]  EXP_LEN       =
        BURST_LEN[feat_pkg::LEN_WIDTH-1:0];

    localparam int unsigned STREAM_PIX  = 3000;
    localparam int unsigned RELOADS     = 4;
    localparam int unsigned RELOAD_PIX  = 200;
    localparam int unsigned TIMEOUT_CYC = (STREAM_PIX + RELOADS * RELOAD_PIX) * 20 + 2000;

    logic                  s_clk;
    logic                  s_rst;
    feat_pkg::ddr_rd_rsp_t ddr_rsp;
    feat_pkg::ddr_rd_req_t ddr_req;
    logic                  data_ready;
    logic                  reload;
    logic                  ddr_gap;
    feat_pkg::feature_px_t pixel;
    logic                  pixel_valid;

    logic [31:0]                     rnd;
    logic [feat_pkg::ADDR_WIDTH-1:0] exp_addr;
    int unsigned pix_idx;   // index from the image base
    int unsigned pix_total;
    int unsigned req_total;
    int unsigned skip_win;  // samples where stale pixels may still show
    int unsigned pix_err;
    int unsigned req_err;
    int unsigned ctrl_err;
    int unsigned cycles;
    logic        seen_req;
    logic        prev_req;
    logic        req_rose;
    logic        run_done = 1'b0;

    feature_loader_top #(
        .BURST_LEN     (BURST_LEN),
        .FIFO_DEPTH    (FIFO_DEPTH),
        .IMG_BASE_ADDR (IMG_BASE_ADDR)
    ) feature_loader_top_inst (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_ddr_rsp     (ddr_rsp),
        .o_ddr_req     (ddr_req),
        .i_data_ready  (data_ready),
        .i_reload      (reload),
        .o_pixel       (pixel),
        .o_pixel_valid (pixel_valid)
    );

    ddr_burst_model ddr_burst_model_inst (
        .s_clk (s_clk),
        .s_rst (s_rst),
        .i_req (ddr_req),
        .i_gap (ddr_gap),
        .o_rsp (ddr_rsp)
    );

    initial begin
        s_clk = 1'b0;
        forever #2 s_clk = ~s_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected channels of image pixel idx
    function automatic feat_pkg::feature_px_t expect_pixel(input int unsigned idx);
        logic [31:0]           addr;
        logic [63:0]           word;
        logic [15:0]           px;
        feat_pkg::feature_px_t exp;
        addr    = IMG_BASE_ADDR + 32'((idx / 4) * 8);
        word    = {xorshift32(addr), xorshift32(~addr)};
        px      = word[(idx % 4) * 16 +: 16];
        exp.ch0 = 8'(px[15:11]) << 3;
        exp.ch1 = 8'(px[10:5]) << 2;
        exp.ch2 = 8'(px[4:0]) << 3;
        return exp;
    endfunction

    task automatic compare_pixel(input feat_pkg::feature_px_t got,
                                 input feat_pkg::feature_px_t exp,
                                 input int unsigned idx);
        if (got !== exp) begin
            pix_err++;
            $display("ERR %0t: pixel %0d got %h/%h/%h expected %h/%h/%h", $time, idx,
                     got.ch0, got.ch1, got.ch2, exp.ch0, exp.ch1, exp.ch2);
        end
    endtask

    task automatic compare_addr(input logic [feat_pkg::ADDR_WIDTH-1:0] got,
                                input logic [feat_pkg::ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            req_err++;
            $display("ERR %0t: burst addr %h expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_len(input logic [feat_pkg::LEN_WIDTH-1:0] got,
                               input logic [feat_pkg::LEN_WIDTH-1:0] exp);
        if (got !== exp) begin
            req_err++;
            $display("ERR %0t: burst len %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("checked %0d pixels and %0d bursts, errors pixel %0d burst %0d control %0d",
                 pix_total, req_total, pix_err, req_err, ctrl_err);
    endtask

    task automatic sample_outputs();
        if (s_rst) begin
            if (ddr_req.req || pixel_valid) begin
                ctrl_err++;
                $display("ERR %0t: request or pixel valid high during reset", $time);
            end
        end else begin
            req_rose = ddr_req.req && !prev_req;
            prev_req = ddr_req.req;
            if (req_rose) begin
                seen_req = 1'b1;
                req_total++;
                compare_addr(ddr_req.addr, exp_addr);
                compare_len(ddr_req.len, EXP_LEN);
                exp_addr = exp_addr + ADDR_STEP;
            end
            if (pixel_valid && !seen_req) begin
                ctrl_err++;
                $display("ERR %0t: pixel valid before the first burst request", $time);
            end else if (pixel_valid && skip_win == 0) begin
                compare_pixel(pixel, expect_pixel(pix_idx), pix_idx);
                pix_idx++;
                pix_total++;
            end
            if (skip_win != 0) begin
                skip_win--;
            end
        end
    endtask

    task automatic drive_inputs(input logic do_reload);
        rnd = xorshift32(rnd);
        data_ready <= (rnd % 32'd10) < 32'd7; // ready about 70%
        rnd = xorshift32(rnd);
        ddr_gap <= (rnd[1:0] == 2'b00);
        reload  <= do_reload;
        if (do_reload) begin
            pix_idx  = 0;
            skip_win = 2;
            exp_addr = IMG_BASE_ADDR;
        end
    endtask

    // sample outputs at the falling edge before driving new inputs
    task automatic step(input logic do_reload);
        @(negedge s_clk);
        sample_outputs();
        drive_inputs(do_reload);
    endtask

    task automatic run_until_pixels(input int unsigned n);
        while (pix_idx < n) begin
            step(1'b0);
        end
    endtask

    initial begin
        cycles = 0;
        while (!run_done && cycles < TIMEOUT_CYC) begin
            @(posedge s_clk);
            cycles++;
        end
        if (!run_done) begin
            $display("timeout, pixel stream stalled after %0d cycles", cycles);
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        s_rst      = 1'b1;
        data_ready = 1'b0;
        reload     = 1'b0;
        ddr_gap    = 1'b0;
        rnd        = 32'he3e2_d75a;
        exp_addr   = IMG_BASE_ADDR;
        pix_idx    = 0;
        pix_total  = 0;
        req_total  = 0;
        skip_win   = 0;
        pix_err    = 0;
        req_err    = 0;
        ctrl_err   = 0;
        seen_req   = 1'b0;
        prev_req   = 1'b0;
        req_rose   = 1'b0;

        repeat (5) step(1'b0);
        s_rst <= 1'b0;

        run_until_pixels(STREAM_PIX);

        for (int r = 0; r < RELOADS; r++) begin
            if (r % 2 == 1) begin
                // reload while the burst that just started is still open
                req_rose = 1'b0;
                while (!req_rose) begin
                    step(1'b0);
                end
                step(1'b1);
            end else begin
                rnd = xorshift32(rnd);
                repeat (20 + rnd % 32'd180) step(1'b0);
                step(1'b1);
            end
            run_until_pixels(RELOAD_PIX);
        end

        run_done = 1'b1;
        print_counts();
        if (pix_err + req_err + ctrl_err == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
